// File: biquad/biquad_coeff_regs.sv
`timescale 1ns/1ps

module biquad_coeff_regs (
    input  logic                  aclk,
    input  logic                  rst_i,
    input  biquad_pkg::wb_req_t   wb_req_i,
    output biquad_pkg::wb_rsp_t   wb_rsp_o,
    output biquad_pkg::coef_set_t coef_o
);

    biquad_pkg::coef_reg_e             reg_idx;
    logic                              req_accept;
    logic                              ctrl_load;
    logic                              ack_q;
    logic                              update_q;
    logic [biquad_pkg::DATA_W-1:0]     rd_dat;
    logic [biquad_pkg::DATA_W-1:0]     rd_dat_q;
    biquad_pkg::coef_set_t             shadow_q;
    biquad_pkg::coef_set_t             active_q;

    // sign extend a coefficient to the bus width
    function automatic logic [biquad_pkg::DATA_W-1:0] sext(
        input logic [biquad_pkg::COEF_W-1:0] c
    );
        sext = {{(biquad_pkg::DATA_W - biquad_pkg::COEF_W){c[biquad_pkg::COEF_W-1]}}, c};
    endfunction

    // byte-enabled update of one coefficient, upper unused bits dropped
    function automatic logic [biquad_pkg::COEF_W-1:0] merge_bytes(
        input logic [biquad_pkg::COEF_W-1:0] old_val,
        input logic [biquad_pkg::DATA_W-1:0] wdat,
        input logic [biquad_pkg::SEL_W-1:0]  sel
    );
        logic [biquad_pkg::DATA_W-1:0] w;
        w = sext(old_val);
        for (int i = 0; i < biquad_pkg::SEL_W; i++) begin
            if (sel[i]) begin
                w[8*i +: 8] = wdat[8*i +: 8];
            end
        end
        merge_bytes = w[biquad_pkg::COEF_W-1:0];
    endfunction

    assign reg_idx = biquad_pkg::coef_reg_e'(wb_req_i.adr[6:2]);

    // ack is held off for one cycle after it was high
    assign req_accept = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign ctrl_load  = req_accept && wb_req_i.we && (reg_idx == biquad_pkg::REG_CTRL) &&
                        wb_req_i.sel[0] && wb_req_i.dat[0];

    // readback comes from the shadow set, ctrl and holes read zero
    always_comb begin
        case (reg_idx)
            biquad_pkg::REG_B0: rd_dat = sext(shadow_q.b0);
            biquad_pkg::REG_B1: rd_dat = sext(shadow_q.b1);
            biquad_pkg::REG_B2: rd_dat = sext(shadow_q.b2);
            biquad_pkg::REG_A1: rd_dat = sext(shadow_q.a1);
            biquad_pkg::REG_A2: rd_dat = sext(shadow_q.a2);
            default:            rd_dat = '0;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            update_q <= 1'b0;
            shadow_q <= '0;
            active_q <= '0;
        end else begin
            ack_q    <= req_accept;
            update_q <= ctrl_load;
            // whole set swaps at once
            if (update_q) begin
                active_q <= shadow_q;
            end
            if (req_accept && wb_req_i.we) begin
                case (reg_idx)
                    biquad_pkg::REG_B0: shadow_q.b0 <= merge_bytes(shadow_q.b0, wb_req_i.dat, wb_req_i.sel);
                    biquad_pkg::REG_B1: shadow_q.b1 <= merge_bytes(shadow_q.b1, wb_req_i.dat, wb_req_i.sel);
                    biquad_pkg::REG_B2: shadow_q.b2 <= merge_bytes(shadow_q.b2, wb_req_i.dat, wb_req_i.sel);
                    biquad_pkg::REG_A1: shadow_q.a1 <= merge_bytes(shadow_q.a1, wb_req_i.dat, wb_req_i.sel);
                    biquad_pkg::REG_A2: shadow_q.a2 <= merge_bytes(shadow_q.a2, wb_req_i.dat, wb_req_i.sel);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (req_accept) begin
            rd_dat_q <= rd_dat;
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rd_dat_q;
    assign coef_o       = active_q;

endmodule

// File: biquad/biquad_df1.sv
`timescale 1ns/1ps

module biquad_df1 (
    input  logic                                aclk,
    input  logic                                rst_i,
    input  biquad_pkg::coef_set_t               coef_i,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] dat_i,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] dat_o
);

    // input history
    logic signed [biquad_pkg::SAMPLE_W-1:0] x1_q;
    logic signed [biquad_pkg::SAMPLE_W-1:0] x2_q;
    // output history, y1 is the output register itself
    logic signed [biquad_pkg::SAMPLE_W-1:0] y1_q;
    logic signed [biquad_pkg::SAMPLE_W-1:0] y2_q;

    logic signed [biquad_pkg::ACC_W-1:0]    p_b0;
    logic signed [biquad_pkg::ACC_W-1:0]    p_b1;
    logic signed [biquad_pkg::ACC_W-1:0]    p_b2;
    logic signed [biquad_pkg::ACC_W-1:0]    p_a1;
    logic signed [biquad_pkg::ACC_W-1:0]    p_a2;
    logic signed [biquad_pkg::ACC_W-1:0]    acc;
    logic signed [biquad_pkg::ACC_W-1:0]    acc_rnd;
    logic signed [biquad_pkg::ACC_W-1:0]    acc_shr;
    logic signed [biquad_pkg::SAMPLE_W-1:0] y_sat;
    logic                                   in_range;

    // products at full accumulator width
    assign p_b0 = $signed(coef_i.b0) * dat_i;
    assign p_b1 = $signed(coef_i.b1) * x1_q;
    assign p_b2 = $signed(coef_i.b2) * x2_q;
    assign p_a1 = $signed(coef_i.a1) * y1_q;
    assign p_a2 = $signed(coef_i.a2) * y2_q;

    assign acc = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;

    // round half up, then drop the fraction
    assign acc_rnd = acc + (biquad_pkg::ACC_W'(1) << (biquad_pkg::COEF_FRAC - 1));
    assign acc_shr = acc_rnd >>> biquad_pkg::COEF_FRAC;

    // fits if all bits above the sample msb match the sign
    assign in_range = (&acc_shr[biquad_pkg::ACC_W-1:biquad_pkg::SAMPLE_W-1]) ||
                      !(|acc_shr[biquad_pkg::ACC_W-1:biquad_pkg::SAMPLE_W-1]);

    always_comb begin
        if (in_range) begin
            y_sat = acc_shr[biquad_pkg::SAMPLE_W-1:0];
        end else if (acc_shr[biquad_pkg::ACC_W-1]) begin
            // clip to most negative
            y_sat = {1'b1, {(biquad_pkg::SAMPLE_W-1){1'b0}}};
        end else begin
            y_sat = {1'b0, {(biquad_pkg::SAMPLE_W-1){1'b1}}};
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            x1_q <= '0;
            x2_q <= '0;
            y1_q <= '0;
            y2_q <= '0;
        end else begin
            x1_q <= dat_i;
            x2_q <= x1_q;
            // saturated value is what gets fed back
            y1_q <= y_sat;
            y2_q <= y1_q;
        end
    end

    assign dat_o = y1_q;

endmodule

// File: biquad/biquad_section.sv
`timescale 1ns/1ps

module biquad_section (
    input  logic                                   aclk,
    input  logic                                   rst_i,
    input  biquad_pkg::wb_req_t                    wb_req_i,
    output biquad_pkg::wb_rsp_t                    wb_rsp_o,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] dat_i,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] dat_o
);

    // active coefficients from the register block
    biquad_pkg::coef_set_t active_coef;

    biquad_coeff_regs u_regs (
        .aclk     (aclk),
        .rst_i    (rst_i),
        .wb_req_i (wb_req_i),
        .wb_rsp_o (wb_rsp_o),
        .coef_o   (active_coef)
    );

    // one cycle from dat_i to dat_o
    biquad_df1 u_df1 (
        .aclk   (aclk),
        .rst_i  (rst_i),
        .coef_i (active_coef),
        .dat_i  (dat_i),
        .dat_o  (dat_o)
    );

endmodule

// File: common/biquad_pkg.sv
package biquad_pkg;

    // sample stream
    localparam int SAMPLE_W = 12;

    // coefficients are signed Q3.14
    localparam int COEF_W    = 18;
    localparam int COEF_FRAC = 14;

    // register bus
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // five coef x sample products summed, with headroom
    localparam int ACC_W = COEF_W + SAMPLE_W + 3;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic signed [COEF_W-1:0] b0;
        logic signed [COEF_W-1:0] b1;
        logic signed [COEF_W-1:0] b2;
        logic signed [COEF_W-1:0] a1;
        logic signed [COEF_W-1:0] a2;
    } coef_set_t;

    // word index taken from adr[6:2]
    typedef enum logic [4:0] {
        REG_B0   = 5'd0,
        REG_B1   = 5'd1,
        REG_B2   = 5'd2,
        REG_A1   = 5'd3,
        REG_A2   = 5'd4,
        REG_CTRL = 5'd5
    } coef_reg_e;

endpackage

// File: compile.f
common/biquad_pkg.sv
biquad/biquad_coeff_regs.sv
biquad/biquad_df1.sv
biquad/biquad_section.sv
src/bus_split.sv
src/biquad_x2_wrapper.sv
verif/biquad_x2_assertions.sv
verif/biquad_x2_tb.sv

// File: src/biquad_x2_wrapper.sv
`timescale 1ns/1ps

module biquad_x2_wrapper (
    input  logic                                   aclk,
    input  logic                                   rst_i,
    input  biquad_pkg::wb_req_t                    wb_req_i,
    output biquad_pkg::wb_rsp_t                    wb_rsp_o,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] dat_i,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] dat_o
);

    biquad_pkg::wb_req_t                    sec_a_req;
    biquad_pkg::wb_req_t                    sec_b_req;
    biquad_pkg::wb_rsp_t                    sec_a_rsp;
    biquad_pkg::wb_rsp_t                    sec_b_rsp;
    // section A output, feeds section B
    logic signed [biquad_pkg::SAMPLE_W-1:0] mid_dat;

    // adr[7] low goes to A, high to B
    bus_split u_split (
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .sec_a_req_o (sec_a_req),
        .sec_b_req_o (sec_b_req),
        .sec_a_rsp_i (sec_a_rsp),
        .sec_b_rsp_i (sec_b_rsp)
    );

    biquad_section u_section_a (
        .aclk     (aclk),
        .rst_i    (rst_i),
        .wb_req_i (sec_a_req),
        .wb_rsp_o (sec_a_rsp),
        .dat_i    (dat_i),
        .dat_o    (mid_dat)
    );

    // two cycles of latency in total
    biquad_section u_section_b (
        .aclk     (aclk),
        .rst_i    (rst_i),
        .wb_req_i (sec_b_req),
        .wb_rsp_o (sec_b_rsp),
        .dat_i    (mid_dat),
        .dat_o    (dat_o)
    );

endmodule

// File: src/bus_split.sv
`timescale 1ns/1ps

module bus_split (
    input  biquad_pkg::wb_req_t wb_req_i,
    output biquad_pkg::wb_rsp_t wb_rsp_o,
    output biquad_pkg::wb_req_t sec_a_req_o,
    output biquad_pkg::wb_req_t sec_b_req_o,
    input  biquad_pkg::wb_rsp_t sec_a_rsp_i,
    input  biquad_pkg::wb_rsp_t sec_b_rsp_i
);

    // adr[7] picks the section
    logic sel_b;

    assign sel_b = wb_req_i.adr[biquad_pkg::ADDR_W-1];

    // only cyc is gated, the rest fans out to both
    always_comb begin
        sec_a_req_o     = wb_req_i;
        sec_b_req_o     = wb_req_i;
        sec_a_req_o.cyc = wb_req_i.cyc && !sel_b;
        sec_b_req_o.cyc = wb_req_i.cyc && sel_b;
    end

    // unselected section never reaches the host
    always_comb begin
        if (sel_b) begin
            wb_rsp_o = sec_b_rsp_i;
        end else begin
            wb_rsp_o = sec_a_rsp_i;
        end
    end

endmodule

// File: verif/biquad_x2_assertions.sv
`timescale 1ns/1ps

module biquad_x2_assertions (
    input logic                aclk,
    input logic                rst_i,
    input biquad_pkg::wb_req_t wb_req_i,
    input biquad_pkg::wb_rsp_t wb_rsp_o
);

    // read by the testbench at the end of the run
    int fail_count = 0;

    // single-cycle ack
    ack_single: assert property (@(posedge aclk) disable iff (rst_i)
        wb_rsp_o.ack |=> !wb_rsp_o.ack)
        else begin
            fail_count++;
            $error("ack stayed high for two cycles");
        end

    // ack only answers a request seen the cycle before
    ack_follows_req: assert property (@(posedge aclk) disable iff (rst_i)
        wb_rsp_o.ack |-> $past(wb_req_i.cyc && wb_req_i.stb))
        else begin
            fail_count++;
            $error("ack without a preceding cyc and stb");
        end

    ack_low_after_rst: assert property (@(posedge aclk) rst_i |=> !wb_rsp_o.ack)
        else begin
            fail_count++;
            $error("ack high in the cycle after reset");
        end

endmodule

bind biquad_coeff_regs biquad_x2_assertions u_assert (
    .aclk     (aclk),
    .rst_i    (rst_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o)
);

// File: verif/biquad_x2_tb.sv
`timescale 1ns/1ps

module biquad_x2_tb;

    localparam int N_SAMPLES   = 430;
    localparam int N_BUS_OPS   = 64;
    localparam int BUS_TIMEOUT = 8;
    localparam int WATCHDOG_NS = (N_SAMPLES + N_BUS_OPS * 2) * 4 * 2;

    logic                                   aclk;
    logic                                   rst_i;
    biquad_pkg::wb_req_t                    wb_req;
    biquad_pkg::wb_rsp_t                    wb_rsp;
    logic signed [biquad_pkg::SAMPLE_W-1:0] dat_i;
    logic signed [biquad_pkg::SAMPLE_W-1:0] dat_o;

    logic [31:0]                            lfsr_q;
    int                                     errors;
    int                                     tests_run;
    int                                     tests_failed;
    int                                     clips;
    logic                                   thru_chk;
    logic signed [biquad_pkg::SAMPLE_W-1:0] in_d1;
    logic signed [biquad_pkg::SAMPLE_W-1:0] in_d2;

    // reference model state with index 0 for section A
    int sh [2][5];
    int ac [2][5];
    int x1 [2];
    int x2 [2];
    int y1 [2];
    int y2 [2];
    bit pend [2];

    biquad_x2_wrapper u_dut (
        .aclk     (aclk),
        .rst_i    (rst_i),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .dat_i    (dat_i),
        .dat_o    (dat_o)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic int rand_signed(input int n);
        logic [31:0] v;
        v = take_bits(n);
        return $signed(v << (32 - n)) >>> (32 - n);
    endfunction

    // accumulate, round, shift, saturate
    function automatic int filt(input int s, input int xin);
        longint acc;
        longint lim;
        lim = longint'(1) << (biquad_pkg::SAMPLE_W - 1);
        acc = longint'(ac[s][0]) * xin + longint'(ac[s][1]) * x1[s]
            + longint'(ac[s][2]) * x2[s] - longint'(ac[s][3]) * y1[s]
            - longint'(ac[s][4]) * y2[s];
        acc = (acc + (longint'(1) << (biquad_pkg::COEF_FRAC - 1))) >>> biquad_pkg::COEF_FRAC;
        if (acc > lim - 1) begin
            acc = lim - 1;
        end else if (acc < -lim) begin
            acc = -lim;
        end
        return int'(acc);
    endfunction

    // one clock edge of both model sections
    task automatic model_edge();
        int xin [2];
        int ynew [2];
        xin[0] = dat_i;
        xin[1] = y1[0];
        for (int s = 0; s < 2; s++) begin
            ynew[s] = filt(s, xin[s]);
        end
        for (int s = 0; s < 2; s++) begin
            if (rst_i) begin
                x1[s] = 0;
                x2[s] = 0;
                y1[s] = 0;
                y2[s] = 0;
                sh[s] = '{default: 0};
                ac[s] = '{default: 0};
            end else begin
                x2[s] = x1[s];
                x1[s] = xin[s];
                y2[s] = y1[s];
                y1[s] = ynew[s];
                if (pend[s]) begin
                    ac[s] = sh[s];
                end
            end
            pend[s] = 1'b0;
        end
    endtask

    task automatic tick();
        logic signed [biquad_pkg::SAMPLE_W-1:0] exp_o;
        @(posedge aclk);
        model_edge();
        in_d2 = in_d1;
        in_d1 = dat_i;
        #1;
        exp_o = y1[1];
        if (y1[1] == (1 << (biquad_pkg::SAMPLE_W - 1)) - 1 ||
            y1[1] == -(1 << (biquad_pkg::SAMPLE_W - 1))) begin
            clips++;
        end
        if (dat_o !== exp_o) begin
            $display("** Error: dat_o expected %h got %h at %0t", exp_o, dat_o, $time);
            errors++;
        end
        if (thru_chk && dat_o !== in_d2) begin
            $display("** Error: dat_o expected %h got %h, not dat_i delayed by 2", in_d2, dat_o);
            errors++;
        end
        dat_i = take_bits(biquad_pkg::SAMPLE_W);
    endtask

    task automatic run_samples(input int n);
        repeat (n) tick();
    endtask

    function automatic void model_write(input logic [7:0] adr, input logic [31:0] wdat);
        int s;
        int idx;
        s = adr[7];
        idx = adr[6:2];
        if (idx < biquad_pkg::REG_CTRL) begin
            sh[s][idx] = $signed(wdat << (32 - biquad_pkg::COEF_W)) >>> (32 - biquad_pkg::COEF_W);
        end else if (idx == biquad_pkg::REG_CTRL && wdat[0]) begin
            pend[s] = 1'b1;
        end
    endfunction

    task automatic bus_xfer(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        int waited;
        wb_req = {1'b1, 1'b1, we, adr, wdat, 4'hf};
        waited = 0;
        rdat = '0;
        do begin
            tick();
            waited++;
        end while (!wb_rsp.ack && waited < BUS_TIMEOUT);
        if (!wb_rsp.ack) begin
            $display("no ack from the bus at address %h", adr);
            errors++;
        end else begin
            rdat = wb_rsp.dat;
            if (we) begin
                model_write(adr, wdat);
            end
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        tick();
    endtask

    function automatic logic [7:0] reg_adr(input int s, input int idx);
        return {s[0], idx[4:0], 2'b00};
    endfunction

    task automatic wb_write(input int s, input int idx, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_xfer(1'b1, reg_adr(s, idx), wdat, unused);
    endtask

    task automatic wb_read(input int s, input int idx, output logic [31:0] rdat);
        bus_xfer(1'b0, reg_adr(s, idx), '0, rdat);
    endtask

    task automatic read_check(input int s, input int idx, input logic [31:0] exp_dat);
        logic [31:0] rdat;
        wb_read(s, idx, rdat);
        if (rdat !== exp_dat) begin
            $display("** Error: wb_rsp_o.dat section %0d word %0d expected %h got %h",
                     s, idx, exp_dat, rdat);
            errors++;
        end
    endtask

    task automatic load_coefs(input int s, input int c [5], input bit commit);
        for (int k = 0; k < 5; k++) begin
            wb_write(s, k, c[k]);
        end
        if (commit) begin
            wb_write(s, biquad_pkg::REG_CTRL, 32'h1);
        end
    endtask

    // b up to +-2.0 and |a1| + |a2| below 0.5
    task automatic rand_set(output int c [5]);
        for (int k = 0; k < 3; k++) begin
            c[k] = rand_signed(16);
        end
        c[3] = rand_signed(13);
        c[4] = rand_signed(13);
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int c [5];
        int e0;
        int asrt;
        rst_i = 1'b1;
        wb_req = '0;
        dat_i = '0;
        lfsr_q = 32'ha1170436;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        clips = 0;
        thru_chk = 1'b0;
        in_d1 = '0;
        in_d2 = '0;
        run_samples(2);
        rst_i = 1'b0;

        e0 = errors;
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 5; k++) begin
                wb_write(s, k, rand_signed(biquad_pkg::COEF_W));
            end
        end
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 5; k++) begin
                read_check(s, k, sh[s][k]);
            end
            read_check(s, biquad_pkg::REG_CTRL, '0);
            read_check(s, 7, '0);
        end
        finish_test("register readback", e0);

        e0 = errors;
        c = '{1 << biquad_pkg::COEF_FRAC, 0, 0, 0, 0};
        load_coefs(0, c, 1'b1);
        load_coefs(1, c, 1'b1);
        run_samples(2);
        thru_chk = 1'b1;
        run_samples(20);
        finish_test("pass-through", e0);

        // shadow writes must not reach the datapath
        e0 = errors;
        rand_set(c);
        load_coefs(0, c, 1'b0);
        run_samples(20);
        thru_chk = 1'b0;
        wb_write(0, biquad_pkg::REG_CTRL, 32'h1);
        run_samples(20);
        finish_test("shadow isolation", e0);

        e0 = errors;
        rand_set(c);
        load_coefs(1, c, 1'b1);
        run_samples(30);
        read_check(0, biquad_pkg::REG_B0, sh[0][0]);
        finish_test("section selection", e0);

        e0 = errors;
        clips = 0;
        for (int s = 0; s < 2; s++) begin
            rand_set(c);
            load_coefs(s, c, 1'b1);
        end
        run_samples(300);
        $display("random filtering saw %0d clipped outputs", clips);
        if (clips == 0) begin
            $display("random filtering never drove the output into saturation");
            errors++;
        end
        finish_test("random filtering", e0);

        e0 = errors;
        run_samples(5);
        rst_i = 1'b1;
        run_samples(2);
        rst_i = 1'b0;
        for (int i = 0; i < 20; i++) begin
            tick();
            if (dat_o !== '0) begin
                $display("** Error: dat_o expected %h got %h after reset", 12'h000, dat_o);
                errors++;
            end
        end
        read_check(0, biquad_pkg::REG_B0, '0);
        read_check(1, biquad_pkg::REG_A1, '0);
        finish_test("reset", e0);

        asrt = u_dut.u_section_a.u_regs.u_assert.fail_count +
               u_dut.u_section_b.u_regs.u_assert.fail_count;
        errors += asrt;
        $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, asrt);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
